// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart testbench with verilator, then scan the log.
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_uart \
  -o sim_uart \
  && ./obj_dir/sim_uart > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

// ==== tb_uart.sv ====
/* uart testbench.
   transmit, receive, frame error, overrun and glitch tests on the uart top. */
`timescale 1ns/1ps

module tb_uart import uart_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int BIT_CYCLES  = OVERSAMPLE * CLKS_PER_TICK;
  localparam int NUM_FRAMES  = 21;  // frames on both pins over all tests.
  localparam int WATCHDOG_NS = (NUM_FRAMES * 12 + 40) * BIT_CYCLES * CLK_PERIOD;

  logic       clk, rst_n, tx_valid, tx_ready, rx_valid, rx_ready;
  logic       rx_frame_err, overrun, tx_line, rx_line;
  logic [7:0] tx_data, rx_data;
  logic [8:0] rx_seen[$];  // {frame_err, data} per word taken.
  int         overruns = 0;
  int         errors = 0;
  int         err_mark = 0;
  int         tests_pass = 0;
  int         tests_fail = 0;
  int         seed = 32'h69dad0bf;

  uart_top dut (
    .clk_i(clk), .rst_ni(rst_n), .tx_valid_i(tx_valid), .tx_data_i(tx_data),
    .tx_ready_o(tx_ready), .rx_valid_o(rx_valid), .rx_data_o(rx_data),
    .rx_frame_err_o(rx_frame_err), .rx_ready_i(rx_ready), .tx_o(tx_line),
    .rx_i(rx_line), .overrun_o(overrun)
  );

  tb_uart_line line (.clk_i(clk), .ser_o(rx_line), .ser_i(tx_line));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n && rx_valid && rx_ready) rx_seen.push_back({rx_frame_err, rx_data});
    if (rst_n && overrun) overruns++;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout, the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  a_reset_state: assert property (@(posedge clk) !rst_n |=> (tx_line && !rx_valid && !overrun))
    else begin
      $display("tx_o, rx_valid_o or overrun_o not at idle after a reset cycle");
      errors++;
    end

  a_ready_out_of_reset: assert property (@(posedge clk) $rose(rst_n) |-> tx_ready)
    else begin
      $display("tx_ready_o low when reset ended");
      errors++;
    end

  a_overrun_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    overrun |=> !overrun)
    else begin
      $display("overrun_o held for more than one cycle");
      errors++;
    end

  task automatic check_value(input string name, input int exp, input int act);
    a_value: assert (exp == act) else begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic close_test(input string name);
    if (errors == err_mark) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic push_tx(input logic [7:0] b);
    tx_valid = 1'b1;
    tx_data  = b;
    @(posedge clk);
    while (!tx_ready) @(posedge clk);
    #2;
    tx_valid = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    while (line.frames_q.size() < n) @(posedge clk);
    #2;
  endtask

  task automatic wait_words(input int n);
    while (rx_seen.size() < n) @(posedge clk);
    #2;
  endtask

  initial begin
    logic [7:0] b;
    logic [7:0] exp_q[$];
    int         base;
    rst_n    = 1'b0;
    tx_valid = 1'b0;
    tx_data  = '0;
    rx_ready = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_value("tx_idle_after_reset", 1, tx_line);
    b = 8'($random(seed));
    push_tx(b);
    wait_frames(1);
    check_value("single_tx", {1'b1, b}, line.frames_q[0]);
    repeat (BIT_CYCLES) @(posedge clk);  // stop bit over, line back at mark.
    #2;
    check_value("tx_idle_after_frame", 1, tx_line);
    close_test("single_tx");

    // queue fills and stalls the sender.
    for (int i = 0; i < 8; i++) begin
      exp_q.push_back(8'($random(seed)));
      push_tx(exp_q[i]);
    end
    wait_frames(9);
    for (int i = 0; i < 8; i++) begin
      check_value("tx_order", {1'b1, exp_q[i]}, line.frames_q[i + 1]);
    end
    close_test("tx_queue_order");

    base = rx_seen.size();
    exp_q.delete();
    for (int i = 0; i < 3; i++) begin
      exp_q.push_back(8'($random(seed)));
      line.send_frame(exp_q[i], STOP_BIT);
    end
    wait_words(base + 3);
    for (int i = 0; i < 3; i++) check_value("rx_word", {1'b0, exp_q[i]}, rx_seen[base + i]);
    close_test("rx_path");

    base = rx_seen.size();
    b = 8'($random(seed));
    line.send_frame(b, 1'b0);
    wait_words(base + 1);
    check_value("rx_bad_stop", {1'b1, b}, rx_seen[base]);
    b = 8'($random(seed));
    line.send_frame(b, STOP_BIT);
    wait_words(base + 2);
    check_value("rx_after_bad_stop", {1'b0, b}, rx_seen[base + 1]);
    close_test("frame_error");

    rx_ready = 1'b0;
    base = overruns;
    exp_q.delete();
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      exp_q.push_back(8'($random(seed)));
      line.send_frame(exp_q[i], STOP_BIT);
    end
    check_value("overrun_pulses", 2, overruns - base);
    base = rx_seen.size();
    rx_ready = 1'b1;
    repeat (2 * FIFO_DEPTH) @(posedge clk);  // drains one word per cycle.
    #2;
    check_value("overrun_kept", FIFO_DEPTH, rx_seen.size() - base);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      check_value("overrun_order", {1'b0, exp_q[i]}, rx_seen[base + i]);
    end
    close_test("overrun");

    base = rx_seen.size();
    line.send_glitch(BIT_CYCLES / 4);
    // long enough for a false frame to land.
    repeat (FRAME_BITS * BIT_CYCLES) @(posedge clk);
    #2;
    check_value("glitch_words", 0, rx_seen.size() - base);
    b = 8'($random(seed));
    line.send_frame(b, STOP_BIT);
    wait_words(base + 1);
    check_value("rx_after_glitch", {1'b0, b}, rx_seen[base]);
    close_test("glitch_reject");

    $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_uart_line.sv ====
/* serial line model.
   drives 8n1 frames onto the uart receive pin and decodes frames from its transmit pin. */
`timescale 1ns/1ps

module tb_uart_line import uart_pkg::*; (
  input  logic clk_i,
  output logic ser_o,
  input  logic ser_i
);

  localparam int BIT_CYCLES = OVERSAMPLE * CLKS_PER_TICK;

  logic       ser_q = 1'b1;
  logic [8:0] frames_q[$];  // {frame ok, byte} per decoded frame.

  assign ser_o = ser_q;

  // keep the level for n cycles, then step just past the edge.
  task automatic hold(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  task automatic send_frame(input logic [DATA_BITS-1:0] b, input logic stop);
    logic [FRAME_BITS-1:0] bits;
    bits = {stop, b, START_BIT};
    hold(1);
    for (int i = 0; i < FRAME_BITS; i++) begin
      ser_q = bits[i];  // lsb first.
      hold(BIT_CYCLES);
    end
    ser_q = 1'b1;  // one bit of idle mark.
    hold(BIT_CYCLES);
  endtask

  task automatic send_glitch(input int len);
    hold(1);
    ser_q = 1'b0;
    hold(len);
    ser_q = 1'b1;
    hold(2 * BIT_CYCLES);
  endtask

  // decoder, samples each bit at its midpoint.
  always begin : decode
    logic [DATA_BITS-1:0] b;
    logic                 ok;
    @(negedge ser_i);
    repeat (BIT_CYCLES / 2) @(posedge clk_i);
    ok = (ser_i == START_BIT);
    for (int i = 0; i < DATA_BITS; i++) begin
      repeat (BIT_CYCLES) @(posedge clk_i);
      b[i] = ser_i;
    end
    repeat (BIT_CYCLES) @(posedge clk_i);
    frames_q.push_back({ok && (ser_i == STOP_BIT), b});
  end

endmodule

// ==== uart_ctrl.sv ====
/* uart control.
   tick divider, transmit dispatch from the queue, receive push and overrun. */
`timescale 1ns/1ps

module uart_ctrl import uart_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  output logic                 tick_o,
  input  logic                 txq_valid_i,
  input  logic [DATA_BITS-1:0] txq_byte_i,
  output logic                 txq_pop_o,
  input  logic                 tx_busy_i,
  output logic                 tx_start_o,
  output logic [DATA_BITS-1:0] tx_byte_o,
  input  logic                 rx_done_i,
  input  rx_word_t             rx_word_i,
  input  logic                 rxq_ready_i,
  output logic                 rxq_push_o,
  output rx_word_t             rxq_word_o,
  output logic                 overrun_o
);

  logic [TICK_DIV_W-1:0] div_cnt_q;
  logic                  start_q;  // popped byte on its way to the shifter.
  logic [DATA_BITS-1:0]  byte_q;
  logic                  overrun_q;

  // oversample tick.
  assign tick_o = (div_cnt_q == TICK_DIV_W'(CLKS_PER_TICK - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      div_cnt_q <= '0;
    end else if (tick_o) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + TICK_DIV_W'(1);
    end
  end

  // no second pop while the first byte is still in flight.
  assign txq_pop_o = txq_valid_i && !tx_busy_i && !start_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else begin
      start_q <= txq_pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (txq_pop_o) begin
      byte_q <= txq_byte_i;
    end
  end

  assign tx_start_o = start_q;
  assign tx_byte_o  = byte_q;

  // push if there is room, else drop and flag.
  assign rxq_push_o = rx_done_i && rxq_ready_i;
  assign rxq_word_o = rx_word_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      overrun_q <= 1'b0;
    end else begin
      overrun_q <= rx_done_i && !rxq_ready_i;
    end
  end

  assign overrun_o = overrun_q;

  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tx_start_o && tx_busy_i))
    else $error("uart_ctrl: tx_start while transmitter busy");

endmodule

// ==== uart_fifo.sv ====
/* uart fifo.
   circular buffer of any payload type with valid/ready on both sides. */
`timescale 1ns/1ps

module uart_fifo #(
  parameter type         T     = logic [7:0],
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic in_valid_i,
  input  T     in_data_i,
  output logic in_ready_o,
  output logic out_valid_o,
  output T     out_data_o,
  input  logic out_ready_i
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  T              mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + AW'(1);
  endfunction

  assign out_valid_o = (count_q != '0);
  // full but popping this cycle still takes a word.
  assign in_ready_o  = (count_q != CW'(DEPTH)) || out_ready_i;
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;
  assign out_data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CW'(1);
        2'b01:   count_q <= count_q - CW'(1);
        default: count_q <= count_q;  // idle or push and pop.
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CW'(DEPTH))
    else $error("uart_fifo: count above depth");

  // an empty fifo can only grow by one.
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q == '0) |=> (count_q <= CW'(1)))
    else $error("uart_fifo: count underflow");

endmodule

// ==== uart_pkg.sv ====
/* uart package.
   line rate, frame layout and the received word type. */
package uart_pkg;

  // line timing.
  localparam int unsigned CLK_FREQ   = 50_000_000;  // hz.
  localparam int unsigned BAUD       = 115_200;
  localparam int unsigned OVERSAMPLE = 16;          // ticks per bit.

  // rounded clock cycles per oversample tick.
  localparam int unsigned CLKS_PER_TICK =
    (CLK_FREQ + (BAUD * OVERSAMPLE) / 2) / (BAUD * OVERSAMPLE);
  localparam int unsigned TICK_DIV_W = $clog2(CLKS_PER_TICK + 1);

  localparam int unsigned FIFO_DEPTH = 4;

  // 8n1 frame.
  localparam int unsigned DATA_BITS  = 8;
  localparam int unsigned FRAME_BITS = DATA_BITS + 2;  // start, data, stop.
  localparam logic        START_BIT  = 1'b0;
  localparam logic        STOP_BIT   = 1'b1;

  // counter widths.
  localparam int unsigned TICK_W = $clog2(OVERSAMPLE);
  localparam int unsigned BIT_W  = $clog2(FRAME_BITS);
  localparam int unsigned DBIT_W = $clog2(DATA_BITS);

  // byte as received, with its stop bit check.
  typedef struct packed {
    logic                 frame_err;
    logic [DATA_BITS-1:0] data;
  } rx_word_t;

endpackage

// ==== uart_rx.sv ====
/* uart receiver.
   finds the start bit, samples each bit at mid-bit and checks the stop bit. */
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     tick_i,
  input  logic     rx_i,
  output logic     done_o,
  output rx_word_t word_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e            state_q;
  logic [1:0]           sync_q;
  logic [TICK_W-1:0]    tick_cnt_q;
  logic [DBIT_W-1:0]    bit_cnt_q;
  logic [DATA_BITS-1:0] data_q;
  rx_word_t             word_q;
  logic                 done_q;
  logic                 rx_s;
  logic                 half_pt;
  logic                 full_pt;

  assign rx_s    = sync_q[1];
  assign half_pt = (tick_cnt_q == TICK_W'(OVERSAMPLE / 2 - 1));
  assign full_pt = (tick_cnt_q == TICK_W'(OVERSAMPLE - 1));

  // two flop synchronizer, idles high.
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= RX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (tick_i) begin
        case (state_q)
          RX_IDLE: begin
            if (!rx_s) begin
              state_q    <= RX_START;
              tick_cnt_q <= '0;
            end
          end
          RX_START: begin
            if (half_pt) begin
              tick_cnt_q <= '0;
              bit_cnt_q  <= '0;
              state_q    <= rx_s ? RX_IDLE : RX_DATA;  // high again is a glitch.
            end else begin
              tick_cnt_q <= tick_cnt_q + TICK_W'(1);
            end
          end
          RX_DATA: begin
            if (full_pt) begin
              tick_cnt_q <= '0;
              if (bit_cnt_q == DBIT_W'(DATA_BITS - 1)) begin
                state_q <= RX_STOP;
              end else begin
                bit_cnt_q <= bit_cnt_q + DBIT_W'(1);
              end
            end else begin
              tick_cnt_q <= tick_cnt_q + TICK_W'(1);
            end
          end
          RX_STOP: begin
            if (full_pt) begin
              tick_cnt_q <= '0;
              state_q    <= RX_IDLE;
              done_q     <= 1'b1;
            end else begin
              tick_cnt_q <= tick_cnt_q + TICK_W'(1);
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  // lsb arrives first.
  always_ff @(posedge clk_i) begin
    if (tick_i && full_pt) begin
      if (state_q == RX_DATA) begin
        data_q <= {rx_s, data_q[DATA_BITS-1:1]};
      end
      if (state_q == RX_STOP) begin
        word_q.data      <= data_q;
        word_q.frame_err <= (rx_s != STOP_BIT);
      end
    end
  end

  assign done_o = done_q;
  assign word_o = word_q;

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("uart_rx: done held longer than one cycle");

endmodule

// ==== uart_top.sv ====
/* uart top level.
   fifo buffered 8n1 transmitter and receiver with valid/ready ports. */
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 tx_valid_i,
  input  logic [DATA_BITS-1:0] tx_data_i,
  output logic                 tx_ready_o,
  output logic                 rx_valid_o,
  output logic [DATA_BITS-1:0] rx_data_o,
  output logic                 rx_frame_err_o,
  input  logic                 rx_ready_i,
  output logic                 tx_o,
  input  logic                 rx_i,
  output logic                 overrun_o
);

  logic                 tick;
  logic                 txq_valid;
  logic [DATA_BITS-1:0] txq_byte;
  logic                 txq_pop;
  logic                 tx_busy;
  logic                 tx_start;
  logic [DATA_BITS-1:0] tx_byte;
  logic                 rx_done;
  rx_word_t             rx_word;
  logic                 rxq_ready;
  logic                 rxq_push;
  rx_word_t             rxq_word;
  rx_word_t             rxq_out;

  uart_fifo #(
    .T     (logic [DATA_BITS-1:0]),
    .DEPTH (FIFO_DEPTH)
  ) u_tx_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (tx_valid_i),
    .in_data_i   (tx_data_i),
    .in_ready_o  (tx_ready_o),
    .out_valid_o (txq_valid),
    .out_data_o  (txq_byte),
    .out_ready_i (txq_pop)
  );

  uart_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tick_o      (tick),
    .txq_valid_i (txq_valid),
    .txq_byte_i  (txq_byte),
    .txq_pop_o   (txq_pop),
    .tx_busy_i   (tx_busy),
    .tx_start_o  (tx_start),
    .tx_byte_o   (tx_byte),
    .rx_done_i   (rx_done),
    .rx_word_i   (rx_word),
    .rxq_ready_i (rxq_ready),
    .rxq_push_o  (rxq_push),
    .rxq_word_o  (rxq_word),
    .overrun_o   (overrun_o)
  );

  uart_tx u_tx (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .tick_i  (tick),
    .start_i (tx_start),
    .byte_i  (tx_byte),
    .busy_o  (tx_busy),
    .tx_o    (tx_o)
  );

  uart_rx u_rx (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tick_i (tick),
    .rx_i   (rx_i),
    .done_o (rx_done),
    .word_o (rx_word)
  );

  uart_fifo #(
    .T     (rx_word_t),
    .DEPTH (FIFO_DEPTH)
  ) u_rx_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (rxq_push),
    .in_data_i   (rxq_word),
    .in_ready_o  (rxq_ready),
    .out_valid_o (rx_valid_o),
    .out_data_o  (rxq_out),
    .out_ready_i (rx_ready_i)
  );

  assign rx_data_o      = rxq_out.data;
  assign rx_frame_err_o = rxq_out.frame_err;

endmodule

// ==== uart_tx.sv ====
/* uart transmitter.
   shifts one byte out as an 8n1 frame, one bit per oversample period. */
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 tick_i,
  input  logic                 start_i,
  input  logic [DATA_BITS-1:0] byte_i,
  output logic                 busy_o,
  output logic                 tx_o
);

  logic [FRAME_BITS-1:0] shift_q;
  logic [TICK_W-1:0]     tick_cnt_q;
  logic [BIT_W-1:0]      bit_cnt_q;
  logic                  busy_q;
  logic                  armed_q;  // frame loaded, waiting for a tick.
  logic                  tx_q;
  logic                  load;
  logic                  bit_end;
  logic                  advance;

  assign load    = start_i && !busy_q;
  assign bit_end = (tick_cnt_q == TICK_W'(OVERSAMPLE - 1));
  assign advance = busy_q && tick_i && (armed_q || bit_end);

  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= {STOP_BIT, byte_i, START_BIT};
    end else if (advance) begin
      shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      armed_q    <= 1'b0;
      tx_q       <= 1'b1;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (load) begin
      busy_q  <= 1'b1;
      armed_q <= 1'b1;
    end else if (busy_q && tick_i) begin
      if (advance) begin
        tick_cnt_q <= '0;
        armed_q    <= 1'b0;
        if (armed_q) begin
          bit_cnt_q <= '0;
          tx_q      <= shift_q[0];  // start bit.
        end else if (bit_cnt_q == BIT_W'(FRAME_BITS - 1)) begin
          busy_q <= 1'b0;
          tx_q   <= STOP_BIT;  // back to idle mark.
        end else begin
          bit_cnt_q <= bit_cnt_q + BIT_W'(1);
          tx_q      <= shift_q[0];
        end
      end else begin
        tick_cnt_q <= tick_cnt_q + TICK_W'(1);
      end
    end
  end

  assign busy_o = busy_q;
  assign tx_o   = tx_q;

  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_o)
    else $error("uart_tx: start while busy");

endmodule

// ==== verilog.f ====
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_ctrl.sv
uart_top.sv
tb_uart_line.sv
tb_uart.sv
